// ==== include/cpu_macros.svh ====
// cpu macros
// word width, register count, reset PC and the opcode/funct encodings
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define WORD_W  32
`define REG_N   32
`define PC_INIT 32'h0000_0000

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDIU 6'h09
`define OP_ORI   6'h0D
`define OP_LUI   6'h0F
`define OP_LW    6'h23
`define OP_SW    6'h2B
`define OP_HALT  6'h3F

// funct field, r-type only
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_SLT  6'h2A

`endif

// ==== hw/cpu_types_pkg.sv ====
// cpu types
// instruction formats, ALU operations and the pipeline latch payloads
`include "cpu_macros.svh"

package cpu_types_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [$clog2(`REG_N)-1:0] reg_idx_t;

  // three views of the same 32 instruction bits
  typedef struct packed {
    logic [5:0] opcode;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fields_t;

  typedef struct packed {
    logic [5:0]  opcode;
    reg_idx_t    rs;
    reg_idx_t    rt;
    logic [15:0] imm;
  } i_fields_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } j_fields_t;

  typedef union packed {
    r_fields_t r;
    i_fields_t i;
    j_fields_t j;
  } instr_t;

  // add must stay at zero, a bubble decodes to it
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_LUI
  } alu_op_t;

  typedef enum logic [1:0] {
    FWD_RF,
    FWD_MEM,
    FWD_WB
  } fwd_sel_t;

  typedef struct packed {
    word_t  pc4;
    instr_t instr;
    logic   valid;
  } fetch_out_t;

  typedef struct packed {
    word_t       pc4;
    word_t       rdat_a;
    word_t       rdat_b;
    word_t       imm_ext;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    wsel;
    alu_op_t     alu_op;
    logic        alu_src;
    logic        reg_wr;
    logic        mem_rd;
    logic        mem_wr;
    logic        beq;
    logic        bne;
    logic        jmp;
    logic        halt;
    logic [25:0] jaddr;
  } decode_out_t;

  typedef struct packed {
    word_t    alu_out;
    word_t    store_data;
    reg_idx_t wsel;
    logic     reg_wr;
    logic     mem_rd;
    logic     mem_wr;
    logic     halt;
  } exec_out_t;

  typedef struct packed {
    word_t    alu_out;
    word_t    load_data;
    reg_idx_t wsel;
    logic     reg_wr;
    logic     mem_to_reg;
  } mem_out_t;

endpackage

// ==== hw/pipe_latch.sv ====
// pipeline latch
// one register stage between two pipe stages, for any payload struct
// flush loads a bubble and wins over stall, stall holds the contents

module pipe_latch #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     stall,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // all-zero payload is a no-op for every stage
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      q <= '0;
    end
    else if (flush)
    begin
      // squashed slot, becomes a bubble
      q <= '0;
    end
    else if (!stall)
    begin
      q <= d;
    end
  end

endmodule

// ==== hw/hazard_unit.sv ====
// hazard unit and its interface
// forwarding selects, load-use stall and branch flush

interface hazard_if (
  input logic CLK,
  input logic nRST
);
  cpu_types_pkg::reg_idx_t rs;
  cpu_types_pkg::reg_idx_t rt;
  cpu_types_pkg::reg_idx_t ex_rs;
  cpu_types_pkg::reg_idx_t ex_rt;
  cpu_types_pkg::reg_idx_t ex_wsel;
  logic                    ex_mem_rd;
  cpu_types_pkg::reg_idx_t mem_wsel;
  logic                    mem_reg_wr;
  cpu_types_pkg::reg_idx_t wb_wsel;
  logic                    wb_reg_wr;
  cpu_types_pkg::word_t    wb_data;
  cpu_types_pkg::fwd_sel_t fwd_a;
  cpu_types_pkg::fwd_sel_t fwd_b;
  logic                    load_stall;
  logic                    flush;
  logic                    branch_taken;

  modport hazard (
    input  CLK, nRST, rs, rt, ex_rs, ex_rt, ex_wsel, ex_mem_rd,
    input  mem_wsel, mem_reg_wr, wb_wsel, wb_reg_wr, branch_taken,
    output fwd_a, fwd_b, load_stall, flush
  );
  modport decode (output rs, rt);
  modport exec (input fwd_a, fwd_b, wb_data, output ex_rs, ex_rt, branch_taken);
endinterface

module hazard_unit (
  hazard_if.hazard hz
);

  // memory stage is younger than writeback so it wins
  function automatic cpu_types_pkg::fwd_sel_t fwd_pick(
    cpu_types_pkg::reg_idx_t src,
    cpu_types_pkg::reg_idx_t mem_wsel,
    logic                    mem_wr,
    cpu_types_pkg::reg_idx_t wb_wsel,
    logic                    wb_wr
  );
    cpu_types_pkg::fwd_sel_t sel;
    sel = cpu_types_pkg::FWD_RF;
    if (src != '0 && wb_wr && wb_wsel == src)
      sel = cpu_types_pkg::FWD_WB;
    if (src != '0 && mem_wr && mem_wsel == src)
      sel = cpu_types_pkg::FWD_MEM;
    return sel;
  endfunction

  assign hz.fwd_a = fwd_pick(hz.ex_rs, hz.mem_wsel, hz.mem_reg_wr, hz.wb_wsel, hz.wb_reg_wr);
  assign hz.fwd_b = fwd_pick(hz.ex_rt, hz.mem_wsel, hz.mem_reg_wr, hz.wb_wsel, hz.wb_reg_wr);

  // load in execute feeding the instruction in decode
  assign hz.load_stall = hz.ex_mem_rd && (hz.ex_wsel != '0) &&
                         (hz.ex_wsel == hz.rs || hz.ex_wsel == hz.rt);
  assign hz.flush      = hz.branch_taken;

  // operand a only taken from a stage that really writes
  a_fwd_a_src: assert property (@(posedge hz.CLK) disable iff (!hz.nRST)
    (hz.fwd_a != cpu_types_pkg::FWD_RF) |->
      ((hz.fwd_a == cpu_types_pkg::FWD_MEM) ? hz.mem_reg_wr : hz.wb_reg_wr));

  // decode drops r0 writes, so the memory stage never offers r0
  a_mem_not_r0: assert property (@(posedge hz.CLK) disable iff (!hz.nRST)
    hz.mem_reg_wr |-> (hz.mem_wsel != '0));

  // branch and load never share the execute slot
  a_flush_vs_stall: assert property (@(posedge hz.CLK) disable iff (!hz.nRST)
    hz.flush |-> !hz.load_stall);

endmodule

// ==== hw/fetch_stage.sv ====
// fetch stage
// PC register, next-PC choice and capture of the fetched word
`include "cpu_macros.svh"

module fetch_stage (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      ihit,
  input  logic                      stall,
  input  logic                      branch_taken,
  input  cpu_types_pkg::word_t      branch_target,
  input  cpu_types_pkg::word_t      instr,
  output cpu_types_pkg::word_t      pc,
  output cpu_types_pkg::fetch_out_t out
);

  cpu_types_pkg::word_t pc_plus4;

  assign pc_plus4 = pc + 32'd4;

  // redirect from execute beats everything else
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      pc <= `PC_INIT;
    else if (branch_taken)
      pc <= branch_target;
    else if (ihit && !stall)
      pc <= pc_plus4;
  end

  // no hit means this slot is a bubble
  always_comb
  begin
    out.pc4   = pc_plus4;
    out.instr = instr;
    out.valid = ihit;
  end

endmodule

// ==== hw/decode_stage.sv ====
// decode stage
// control flags, ALU op, immediate extension and the register file
`include "cpu_macros.svh"

module decode_stage (
  input  logic                       CLK,
  input  logic                       nRST,
  input  cpu_types_pkg::fetch_out_t  in,
  input  logic                       wr_en,
  input  cpu_types_pkg::reg_idx_t    wr_sel,
  input  cpu_types_pkg::word_t       wr_data,
  hazard_if.decode                   hz,
  output cpu_types_pkg::decode_out_t out
);

  cpu_types_pkg::word_t  regs [`REG_N];
  cpu_types_pkg::instr_t ins;
  logic                  sign_ext;

  assign ins = in.instr;

  // bubble sources read as r0 so they never match
  assign hz.rs = in.valid ? ins.r.rs : '0;
  assign hz.rt = in.valid ? ins.r.rt : '0;

  // r0 is hardwired, same-cycle write is passed straight through
  function automatic cpu_types_pkg::word_t read_reg(cpu_types_pkg::reg_idx_t sel);
    if (sel == '0)
      return '0;
    else if (wr_en && sel == wr_sel)
      return wr_data;
    else
      return regs[sel];
  endfunction

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < `REG_N; i++)
        regs[i] <= '0;
    end
    else if (wr_en && wr_sel != '0)
    begin
      regs[wr_sel] <= wr_data;
    end
  end

  always_comb
  begin
    out        = '0;
    sign_ext   = 1'b1;
    out.pc4    = in.pc4;
    out.rs     = ins.r.rs;
    out.rt     = ins.r.rt;
    out.jaddr  = ins.j.target;
    out.rdat_a = read_reg(ins.r.rs);
    out.rdat_b = read_reg(ins.r.rt);
    if (in.valid)
    begin
      case (ins.r.opcode)
        `OP_RTYPE:
        begin
          out.wsel   = ins.r.rd;
          out.reg_wr = 1'b1;
          case (ins.r.funct)
            `FN_ADDU: out.alu_op = cpu_types_pkg::ALU_ADD;
            `FN_SUBU: out.alu_op = cpu_types_pkg::ALU_SUB;
            `FN_AND:  out.alu_op = cpu_types_pkg::ALU_AND;
            `FN_OR:   out.alu_op = cpu_types_pkg::ALU_OR;
            `FN_SLT:  out.alu_op = cpu_types_pkg::ALU_SLT;
            // unsupported funct acts as a nop
            default:  out.reg_wr = 1'b0;
          endcase
        end
        `OP_ADDIU, `OP_ORI, `OP_LUI, `OP_LW:
        begin
          out.wsel    = ins.i.rt;
          out.reg_wr  = 1'b1;
          out.alu_src = 1'b1;
          out.mem_rd  = (ins.r.opcode == `OP_LW);
          // ori is the only zero-extended immediate
          sign_ext    = (ins.r.opcode != `OP_ORI);
          if (ins.r.opcode == `OP_ORI)
            out.alu_op = cpu_types_pkg::ALU_OR;
          else if (ins.r.opcode == `OP_LUI)
            out.alu_op = cpu_types_pkg::ALU_LUI;
        end
        `OP_SW:
        begin
          out.alu_src = 1'b1;
          out.mem_wr  = 1'b1;
        end
        `OP_BEQ:  out.beq  = 1'b1;
        `OP_BNE:  out.bne  = 1'b1;
        `OP_J:    out.jmp  = 1'b1;
        `OP_HALT: out.halt = 1'b1;
        default:  out.halt = 1'b0;
      endcase
      // writes to r0 are dropped here
      if (out.wsel == '0)
        out.reg_wr = 1'b0;
    end
    out.imm_ext = sign_ext ? {{16{ins.i.imm[15]}}, ins.i.imm} : {16'h0000, ins.i.imm};
  end

  // writeback never targets r0 since decode drops those writes
  a_no_r0_write: assert property (@(posedge CLK) disable iff (!nRST)
    wr_en |-> (wr_sel != '0));

endmodule

// ==== hw/exec_stage.sv ====
// execute stage
// operand forwarding, ALU and branch/jump resolution

module exec_stage (
  input  cpu_types_pkg::decode_out_t in,
  input  cpu_types_pkg::word_t       fwd_mem,
  hazard_if.exec                     hz,
  output cpu_types_pkg::exec_out_t   out,
  output cpu_types_pkg::word_t       branch_target
);

  cpu_types_pkg::word_t op_a;
  cpu_types_pkg::word_t op_b;
  cpu_types_pkg::word_t alu_b;
  cpu_types_pkg::word_t alu_y;
  logic                 equal;

  // hazard unit matches these against older destinations
  assign hz.ex_rs = in.rs;
  assign hz.ex_rt = in.rt;

  assign op_a = (hz.fwd_a == cpu_types_pkg::FWD_MEM) ? fwd_mem :
                (hz.fwd_a == cpu_types_pkg::FWD_WB)  ? hz.wb_data : in.rdat_a;
  assign op_b = (hz.fwd_b == cpu_types_pkg::FWD_MEM) ? fwd_mem :
                (hz.fwd_b == cpu_types_pkg::FWD_WB)  ? hz.wb_data : in.rdat_b;
  assign alu_b = in.alu_src ? in.imm_ext : op_b;

  always_comb
  begin
    case (in.alu_op)
      cpu_types_pkg::ALU_SUB: alu_y = op_a - alu_b;
      cpu_types_pkg::ALU_AND: alu_y = op_a & alu_b;
      cpu_types_pkg::ALU_OR:  alu_y = op_a | alu_b;
      cpu_types_pkg::ALU_SLT: alu_y = ($signed(op_a) < $signed(alu_b)) ? 32'd1 : 32'd0;
      cpu_types_pkg::ALU_LUI: alu_y = {alu_b[15:0], 16'h0000};
      default:                alu_y = op_a + alu_b;
    endcase
  end

  // compare uses forwarded register values, never the immediate
  assign equal           = (op_a == op_b);
  assign hz.branch_taken = (in.beq & equal) | (in.bne & ~equal) | in.jmp;
  assign branch_target   = in.jmp ? {in.pc4[31:28], in.jaddr, 2'b00}
                                  : in.pc4 + {in.imm_ext[29:0], 2'b00};

  always_comb
  begin
    out.alu_out    = alu_y;
    out.store_data = op_b;
    out.wsel       = in.wsel;
    out.reg_wr     = in.reg_wr;
    out.mem_rd     = in.mem_rd;
    out.mem_wr     = in.mem_wr;
    out.halt       = in.halt;
  end

endmodule

// ==== hw/datapath.sv ====
// pipelined datapath top
// five stages with latches, hazard unit, memory access and writeback
// memory side uses a wait/hit handshake to external memories

module datapath (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 ihit,
  input  cpu_types_pkg::word_t imem_load,
  output cpu_types_pkg::word_t imem_addr,
  output logic                 imem_ren,
  input  logic                 dhit,
  input  cpu_types_pkg::word_t dmem_load,
  output logic                 dmem_ren,
  output logic                 dmem_wen,
  output cpu_types_pkg::word_t dmem_addr,
  output cpu_types_pkg::word_t dmem_store,
  output logic                 halt
);

  cpu_types_pkg::fetch_out_t  f_out;
  cpu_types_pkg::fetch_out_t  flat_q;
  cpu_types_pkg::decode_out_t d_out;
  cpu_types_pkg::decode_out_t dlat_q;
  cpu_types_pkg::exec_out_t   e_out;
  cpu_types_pkg::exec_out_t   elat_q;
  cpu_types_pkg::mem_out_t    m_in;
  cpu_types_pkg::mem_out_t    mlat_q;
  cpu_types_pkg::word_t       br_target;
  cpu_types_pkg::word_t       wb_value;
  logic                       mem_wait;
  logic                       redirect;
  logic                       stop;

  hazard_if hz (.CLK(CLK), .nRST(nRST));

  // data access outstanding, everything holds
  assign mem_wait = (dmem_ren | dmem_wen) & ~dhit;
  // branch waits until the pipe moves again
  assign redirect = hz.flush & ~mem_wait;
  // halt in memory stage or already latched
  assign stop     = elat_q.halt | halt;

  assign imem_ren = ~halt;

  fetch_stage u_fetch (
    .CLK(CLK), .nRST(nRST), .ihit(ihit),
    .stall(hz.load_stall | mem_wait | halt),
    .branch_taken(redirect), .branch_target(br_target),
    .instr(imem_load), .pc(imem_addr), .out(f_out)
  );

  pipe_latch #(.payload_t(cpu_types_pkg::fetch_out_t)) u_flatch (
    .CLK(CLK), .nRST(nRST), .stall(hz.load_stall | mem_wait),
    .flush(redirect | stop), .d(f_out), .q(flat_q)
  );

  decode_stage u_decode (
    .CLK(CLK), .nRST(nRST), .in(flat_q),
    .wr_en(mlat_q.reg_wr), .wr_sel(mlat_q.wsel), .wr_data(wb_value),
    .hz(hz), .out(d_out)
  );

  // load-use bubble only when the load itself can move on
  pipe_latch #(.payload_t(cpu_types_pkg::decode_out_t)) u_dlatch (
    .CLK(CLK), .nRST(nRST), .stall(mem_wait),
    .flush(redirect | (hz.load_stall & ~mem_wait) | stop),
    .d(d_out), .q(dlat_q)
  );

  exec_stage u_exec (
    .in(dlat_q), .fwd_mem(elat_q.alu_out), .hz(hz),
    .out(e_out), .branch_target(br_target)
  );

  // nothing younger than a halt reaches memory
  pipe_latch #(.payload_t(cpu_types_pkg::exec_out_t)) u_elatch (
    .CLK(CLK), .nRST(nRST), .stall(mem_wait), .flush(stop),
    .d(e_out), .q(elat_q)
  );

  hazard_unit u_hazard (.hz(hz));

  // older destinations for forwarding and load-use
  assign hz.ex_wsel    = dlat_q.wsel;
  assign hz.ex_mem_rd  = dlat_q.mem_rd;
  assign hz.mem_wsel   = elat_q.wsel;
  assign hz.mem_reg_wr = elat_q.reg_wr;
  assign hz.wb_wsel    = mlat_q.wsel;
  assign hz.wb_reg_wr  = mlat_q.reg_wr;
  assign hz.wb_data    = wb_value;

  // memory stage
  assign dmem_ren   = elat_q.mem_rd;
  assign dmem_wen   = elat_q.mem_wr;
  assign dmem_addr  = elat_q.alu_out;
  assign dmem_store = elat_q.store_data;

  always_comb
  begin
    m_in.alu_out    = elat_q.alu_out;
    m_in.load_data  = dmem_load;
    m_in.wsel       = elat_q.wsel;
    m_in.reg_wr     = elat_q.reg_wr;
    m_in.mem_to_reg = elat_q.mem_rd;
  end

  // held through mem_wait so writeback forwarding stays valid
  pipe_latch #(.payload_t(cpu_types_pkg::mem_out_t)) u_mlatch (
    .CLK(CLK), .nRST(nRST), .stall(mem_wait), .flush(1'b0),
    .d(m_in), .q(mlat_q)
  );

  assign wb_value = mlat_q.mem_to_reg ? mlat_q.load_data : mlat_q.alu_out;

  // sticky until reset
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      halt <= 1'b0;
    else if (elat_q.halt)
      halt <= 1'b1;
  end

  // squash after halt keeps the data ports quiet
  a_halt_quiet: assert property (@(posedge CLK) disable iff (!nRST)
    halt |-> !(dmem_ren || dmem_wen));

  // request and address held until dhit
  a_dmem_hold: assert property (@(posedge CLK) disable iff (!nRST)
    mem_wait |=> ((dmem_ren || dmem_wen) && $stable(dmem_addr)));

endmodule

// ==== tests/tb_clock_gen.sv ====
// testbench clock and reset
// CLK with period 20, nRST held low for the first 16 cycles

module tb_clock_gen (
  output logic CLK,
  output logic nRST
);

  initial
  begin
    CLK = 1'b0;
    forever
      #10 CLK = ~CLK;
  end

  // release just after an edge, like every other input
  initial
  begin
    nRST = 1'b0;
    repeat (16)
      @(posedge CLK);
    #2;
    nRST = 1'b1;
  end

endmodule

// ==== tests/datapath_tb.sv ====
// datapath testbench
// memory models with random wait states, a test program, and an
// ISA-level reference that predicts every store and the final data memory
`include "cpu_macros.svh"

module datapath_tb;

  localparam int IMEM_WORDS = 64;
  localparam int DMEM_WORDS = 64;
  // about 70 instructions at up to 4 fetch cycles each, plus data waits
  // and bubbles, stays well below 1000 cycles
  localparam int TIMEOUT_CYCLES = 4000;

  logic                 CLK;
  logic                 nRST;
  logic                 ihit;
  logic                 dhit;
  cpu_types_pkg::word_t imem_load;
  cpu_types_pkg::word_t imem_addr;
  logic                 imem_ren;
  cpu_types_pkg::word_t dmem_load;
  logic                 dmem_ren;
  logic                 dmem_wen;
  cpu_types_pkg::word_t dmem_addr;
  cpu_types_pkg::word_t dmem_store;
  logic                 halt;

  cpu_types_pkg::word_t imem [IMEM_WORDS];
  cpu_types_pkg::word_t dmem [DMEM_WORDS];
  cpu_types_pkg::word_t ref_mem [DMEM_WORDS];
  // expected store sequence, in program order
  cpu_types_pkg::word_t exp_addr [$];
  cpu_types_pkg::word_t exp_data [$];

  int seed;
  int i_wait;
  int d_wait;
  int cycles;
  int store_idx;
  int store_errs;
  int main_errs;

  tb_clock_gen u_clk (.CLK(CLK), .nRST(nRST));

  datapath u_dut (
    .CLK(CLK), .nRST(nRST), .ihit(ihit), .imem_load(imem_load),
    .imem_addr(imem_addr), .imem_ren(imem_ren), .dhit(dhit),
    .dmem_load(dmem_load), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
    .dmem_addr(dmem_addr), .dmem_store(dmem_store), .halt(halt)
  );

  // both memories answer in the same cycle, word addressed
  assign imem_load = imem[imem_addr[7:2]];
  assign dmem_load = dmem[dmem_addr[7:2]];

  function automatic cpu_types_pkg::word_t r_type(logic [5:0] funct, int rs, int rt, int rd);
    return {`OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
  endfunction

  function automatic cpu_types_pkg::word_t i_type(logic [5:0] op, int rs, int rt, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic cpu_types_pkg::word_t j_type(logic [5:0] op, int target);
    return {op, target[25:0]};
  endfunction

  // odd multiplier, so every address bit shows in the word
  function automatic cpu_types_pkg::word_t fill_word(int i);
    return 32'hA5C3_0000 ^ (i * 32'h0001_3579);
  endfunction

  // runs the program one instruction at a time, no pipeline
  function automatic int interpret_program();
    cpu_types_pkg::word_t regs [32];
    cpu_types_pkg::word_t pc;
    cpu_types_pkg::word_t ins;
    cpu_types_pkg::word_t sext;
    cpu_types_pkg::word_t addr;
    cpu_types_pkg::word_t a;
    cpu_types_pkg::word_t b;
    logic [4:0]           rt;
    logic [4:0]           rd;
    int                   steps;
    logic                 done;
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
    pc    = `PC_INIT;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < 1000)
    begin
      ins  = imem[pc[7:2]];
      rt   = ins[20:16];
      rd   = ins[15:11];
      a    = regs[ins[25:21]];
      b    = regs[rt];
      sext = {{16{ins[15]}}, ins[15:0]};
      addr = a + sext;
      // pc now holds PC plus 4, the base for branches and J
      pc   = pc + 32'd4;
      steps++;
      case (ins[31:26])
        `OP_RTYPE:
        begin
          case (ins[5:0])
            `FN_ADDU: regs[rd] = a + b;
            `FN_SUBU: regs[rd] = a - b;
            `FN_AND:  regs[rd] = a & b;
            `FN_OR:   regs[rd] = a | b;
            `FN_SLT:  regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:  ;
          endcase
        end
        `OP_ADDIU: regs[rt] = addr;
        `OP_ORI:   regs[rt] = a | {16'h0000, ins[15:0]};
        `OP_LUI:   regs[rt] = {ins[15:0], 16'h0000};
        `OP_LW:    regs[rt] = ref_mem[addr[7:2]];
        `OP_SW:
        begin
          ref_mem[addr[7:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        `OP_BEQ:
        begin
          if (a == b)
            pc = pc + {sext[29:0], 2'b00};
        end
        `OP_BNE:
        begin
          if (a != b)
            pc = pc + {sext[29:0], 2'b00};
        end
        `OP_J:     pc = {pc[31:28], ins[25:0], 2'b00};
        `OP_HALT:  done = 1'b1;
        default:   ;
      endcase
      regs[0] = '0;
    end
    return steps;
  endfunction

  task automatic compare_word(input string name, input cpu_types_pkg::word_t got,
                              input cpu_types_pkg::word_t exp, inout int errs);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      errs++;
    end
  endtask

  task automatic load_program();
    // unused words halt, tagged with their own index
    for (int i = 0; i < IMEM_WORDS; i++)
      imem[i] = j_type(`OP_HALT, i);
    // immediates: negative ADDIU, zero-extended ORI, LUI
    imem[0]  = i_type(`OP_ADDIU, 0, 1, 5);
    imem[1]  = i_type(`OP_ADDIU, 0, 2, -3);
    imem[2]  = i_type(`OP_ORI, 0, 3, 'h8001);
    imem[3]  = i_type(`OP_LUI, 0, 4, 'h1234);
    imem[4]  = i_type(`OP_ORI, 4, 4, 'hABCD);
    // r-type, SLT both ways with a negative operand
    imem[5]  = r_type(`FN_ADDU, 1, 2, 5);
    imem[6]  = r_type(`FN_SUBU, 2, 1, 6);
    imem[7]  = r_type(`FN_AND, 4, 3, 7);
    imem[8]  = r_type(`FN_OR, 1, 3, 8);
    imem[9]  = r_type(`FN_SLT, 2, 1, 9);
    imem[10] = r_type(`FN_SLT, 1, 2, 10);
    imem[11] = i_type(`OP_SW, 0, 5, 0);
    imem[12] = i_type(`OP_SW, 0, 6, 4);
    imem[13] = i_type(`OP_SW, 0, 7, 8);
    imem[14] = i_type(`OP_SW, 0, 8, 12);
    imem[15] = i_type(`OP_SW, 0, 9, 16);
    imem[16] = i_type(`OP_SW, 0, 10, 20);
    imem[17] = i_type(`OP_SW, 0, 2, 24);
    imem[18] = i_type(`OP_SW, 0, 3, 28);
    imem[19] = i_type(`OP_SW, 0, 4, 32);
    // r11 consumed at distance 1, 2 and 3
    imem[20] = i_type(`OP_ADDIU, 0, 11, 7);
    imem[21] = r_type(`FN_ADDU, 11, 1, 12);
    imem[22] = r_type(`FN_SUBU, 2, 11, 13);
    imem[23] = r_type(`FN_OR, 11, 12, 14);
    imem[24] = i_type(`OP_SW, 0, 13, 36);
    imem[25] = i_type(`OP_SW, 0, 12, 40);
    imem[26] = i_type(`OP_SW, 0, 14, 44);
    // load-use, first one reads back the store at 4
    imem[27] = i_type(`OP_LW, 0, 15, 4);
    imem[28] = r_type(`FN_ADDU, 15, 1, 16);
    imem[29] = i_type(`OP_SW, 0, 16, 48);
    imem[30] = i_type(`OP_LW, 0, 17, 200);
    imem[31] = i_type(`OP_SW, 0, 17, 52);
    // branches taken and not taken, skipped stores are wrong path
    imem[32] = i_type(`OP_BEQ, 1, 2, 2);
    imem[33] = i_type(`OP_SW, 0, 1, 56);
    imem[34] = i_type(`OP_BNE, 1, 2, 2);
    imem[35] = i_type(`OP_SW, 0, 2, 60);
    imem[36] = i_type(`OP_SW, 0, 3, 60);
    imem[37] = i_type(`OP_BEQ, 1, 1, 1);
    imem[38] = i_type(`OP_SW, 0, 4, 64);
    imem[39] = i_type(`OP_BNE, 12, 12, 1);
    imem[40] = j_type(`OP_J, 43);
    imem[41] = i_type(`OP_SW, 0, 5, 64);
    imem[42] = i_type(`OP_SW, 0, 6, 64);
    // short loop, backward BNE on a just-written counter
    imem[43] = i_type(`OP_ADDIU, 0, 18, 2);
    imem[44] = r_type(`FN_ADDU, 19, 18, 19);
    imem[45] = i_type(`OP_ADDIU, 18, 18, -1);
    imem[46] = i_type(`OP_BNE, 18, 0, -3);
    imem[47] = i_type(`OP_SW, 0, 19, 64);
    // loaded value straight into a branch compare
    imem[48] = i_type(`OP_LW, 0, 20, 64);
    imem[49] = i_type(`OP_BEQ, 20, 19, 1);
    imem[50] = i_type(`OP_SW, 0, 0, 68);
    imem[51] = i_type(`OP_SW, 0, 20, 68);
    imem[52] = j_type(`OP_HALT, 0);
    imem[53] = i_type(`OP_SW, 0, 1, 72);
  endtask

  // wait states, every input moves 2 units after the rising edge
  initial
  begin
    seed   = 54855;
    ihit   = 1'b0;
    dhit   = 1'b0;
    i_wait = 0;
    d_wait = 0;
    forever
    begin
      @(posedge CLK);
      #2;
      if (i_wait > 0)
      begin
        ihit   = 1'b0;
        i_wait = i_wait - 1;
      end
      else
      begin
        ihit   = 1'b1;
        i_wait = $random(seed) & 3;
      end
      // dhit only answers an open request
      if (!(dmem_ren || dmem_wen))
        dhit = 1'b0;
      else if (d_wait > 0)
      begin
        dhit   = 1'b0;
        d_wait = d_wait - 1;
      end
      else
      begin
        dhit   = 1'b1;
        d_wait = $random(seed) & 3;
      end
    end
  end

  // data memory, store lands mid-cycle before the completing edge
  initial
  begin
    for (int i = 0; i < DMEM_WORDS; i++)
      dmem[i] = fill_word(i);
    forever
    begin
      @(negedge CLK);
      if (nRST && dmem_wen && dhit)
        dmem[dmem_addr[7:2]] = dmem_store;
    end
  end

  // store checker, ports are stable mid-cycle
  initial
  begin
    store_idx  = 0;
    store_errs = 0;
    forever
    begin
      @(negedge CLK);
      if (nRST && dmem_wen && dhit)
      begin
        if (store_idx < exp_addr.size())
        begin
          compare_word("dmem_addr", dmem_addr, exp_addr[store_idx], store_errs);
          compare_word("dmem_store", dmem_store, exp_data[store_idx], store_errs);
        end
        else
        begin
          $display("%0t: store to %h is beyond the expected sequence", $time, dmem_addr);
          store_errs++;
        end
        store_idx++;
      end
      if (nRST && halt && (dmem_ren || dmem_wen))
      begin
        $display("%0t: data memory access after halt", $time);
        store_errs++;
      end
    end
  end

  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge CLK);
      cycles++;
    end
    $display("timeout after %0d cycles, halt never rose", cycles);
    $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    int executed;
    main_errs = 0;
    load_program();
    for (int i = 0; i < DMEM_WORDS; i++)
      ref_mem[i] = fill_word(i);
    executed = interpret_program();
    $display("reference: %0d instructions, %0d stores", executed, exp_addr.size());
    @(posedge nRST);
    // fetch keeps requesting until the pipeline halts
    while (halt !== 1'b1)
    begin
      @(negedge CLK);
      if (halt !== 1'b1)
        compare_word("imem_ren", imem_ren, 1'b1, main_errs);
    end
    // all stores done by the time halt rises
    @(posedge CLK);
    compare_word("store_count", store_idx, exp_addr.size(), main_errs);
    // data port must stay quiet from here on
    repeat (8)
      @(posedge CLK);
    compare_word("store_count", store_idx, exp_addr.size(), main_errs);
    // no instruction requests once halted
    compare_word("imem_ren", imem_ren, 1'b0, main_errs);
    for (int i = 0; i < DMEM_WORDS; i++)
      compare_word($sformatf("dmem[%0d]", i), dmem[i], ref_mem[i], main_errs);
    $display("errors: %0d in store checks, %0d in final checks", store_errs, main_errs);
    if (store_errs == 0 && main_errs == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+include
hw/cpu_types_pkg.sv
hw/pipe_latch.sv
hw/hazard_unit.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/exec_stage.sv
hw/datapath.sv
tests/tb_clock_gen.sv
tests/datapath_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the datapath testbench with Verilator, run it, and check the log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module datapath_tb \
  --Mdir "$BUILD_DIR" -f list.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vdatapath_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
  exit 0
fi
exit 1
